/* cu_bundles.f */
+incdir+include
design/cu_mem_pkg.sv
design/cu_kernel_pkg.sv
design/cu_kernel_control.sv
design/cu_response_router.sv
design/cu_bundle_engine.sv
design/cu_request_arbiter.sv
design/cu_bundles.sv
verification/cu_bundles_props.sv
verification/cu_bundles_tb.sv

/* Bender.yml */
package:
  name: cu_bundles

sources:
  - include_dirs:
      - include
    files:
      - design/cu_mem_pkg.sv
      - design/cu_kernel_pkg.sv
      - design/cu_kernel_control.sv
      - design/cu_response_router.sv
      - design/cu_bundle_engine.sv
      - design/cu_request_arbiter.sv
      - design/cu_bundles.sv
      - target: test
        files:
          - verification/cu_bundles_props.sv
          - verification/cu_bundles_tb.sv

/* verification/cu_bundles_tb.sv */
/*
 * Testbench for the compute unit
 * Clock and reset, LFSR-timed memory model, kernel table, checks and timeout
 */

`timescale 1ns/10ps
`include "cu_bundles_defs.svh"

module cu_bundles_tb;

    localparam int NUM_ROWS    = 5;
    localparam int HOLD_CYCLES = 40;
    localparam int MAX_WORDS   = `CU_NUM_BUNDLES * 256;

    typedef enum logic [1:0] {RD_ALWAYS, RD_HOLD, RD_RANDOM} rd_mode_t;

    typedef struct packed {
        logic [`CU_ADDR_W-1:0] base;
        logic [`CU_CNT_W-1:0]  count;
        rd_mode_t              mode;
        logic [`CU_SUM_W-1:0]  expected;
    } kernel_row_t;

    // One outstanding read in the memory model
    typedef struct packed {
        logic [`CU_BUNDLE_ID_W-1:0] id;
        logic [`CU_ADDR_W-1:0]      addr;
        logic [31:0]                due;
    } mem_entry_t;

    logic                              ap_clk;
    logic                              areset_cu_bundles;
    cu_kernel_pkg::kernel_descriptor_t descriptor_i;
    cu_mem_pkg::mem_packet_t           response_i;
    logic                              request_rd_en_i;
    cu_mem_pkg::mem_packet_t           request_o;
    logic                              done_o;
    logic [`CU_SUM_W-1:0]              result_o;

    kernel_row_t  table_rows [NUM_ROWS];
    kernel_row_t  cur;
    mem_entry_t   pending [$];
    logic         seen [MAX_WORDS];
    logic [31:0]  lfsr_state;
    int unsigned  cycle_cnt;
    int unsigned  row_cycle;
    int unsigned  req_seen;
    int unsigned  timeout_limit;
    logic         kernel_active;
    logic         started;

    cu_bundles cu_bundles_i (
        .ap_clk            (ap_clk),
        .areset_cu_bundles (areset_cu_bundles),
        .descriptor_i      (descriptor_i),
        .response_i        (response_i),
        .request_rd_en_i   (request_rd_en_i),
        .request_o         (request_o),
        .done_o            (done_o),
        .result_o          (result_o)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // ----------------------------
    // Failure reporting
    // ----------------------------
    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_error(input string why);
        $display("ERROR at %0t: %s", $time, why);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s actual 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    // ----------------------------
    // Random bits
    // ----------------------------
    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int n, output int unsigned value);
        value = 0;
        for (int b = 0; b < n; b++) begin
            value      = (value << 1) | lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // ----------------------------
    // Memory model
    // ----------------------------
    task automatic sample_request();
        longint      offset;
        longint      span;
        int unsigned idx;
        int unsigned delay;
        mem_entry_t  entry;
        if (!request_o.valid) begin
            return;
        end
        if (!request_rd_en_i) begin
            report_error("request left while read enable was low");
        end
        if (!kernel_active) begin
            report_error("request seen with no kernel running");
        end
        check_value("request_o.cmd", request_o.payload.meta.cmd, cu_mem_pkg::CMD_READ_REQ);
        offset = longint'(request_o.payload.word.address) - longint'(cur.base);
        span   = longint'(`CU_NUM_BUNDLES) * cur.count * `CU_WORD_BYTES;
        if (offset < 0 || offset >= span || (offset % `CU_WORD_BYTES) != 0) begin
            report_error("request address outside the kernel range");
        end
        idx = int'(offset / `CU_WORD_BYTES);
        // Slice index of the word is the owning bundle
        check_value("request_o.id", request_o.payload.meta.id, idx / cur.count);
        if (seen[idx]) begin
            report_error("same address requested twice in one kernel");
        end
        seen[idx] = 1'b1;
        req_seen++;
        // Answer after 2 to 5 cycles
        take_bits(2, delay);
        entry.id   = request_o.payload.meta.id;
        entry.addr = request_o.payload.word.address;
        entry.due  = cycle_cnt + 2 + delay;
        pending.push_back(entry);
    endtask

    // Oldest due entry first and one response per cycle
    task automatic drive_response();
        int hit;
        hit        = -1;
        response_i = '0;
        for (int i = 0; i < pending.size(); i++) begin
            if (hit < 0 && pending[i].due <= cycle_cnt) begin
                hit = i;
            end
        end
        if (hit >= 0) begin
            response_i.valid             = 1'b1;
            response_i.payload.meta.cmd  = cu_mem_pkg::CMD_READ_RSP;
            response_i.payload.meta.id   = pending[hit].id;
            response_i.payload.word.data = (pending[hit].addr >> 2) + 7;
            pending.delete(hit);
        end
    endtask

    task automatic drive_read_enable();
        int unsigned bit_val;
        if (!kernel_active) begin
            request_rd_en_i = 1'b1;
        end else begin
            case (cur.mode)
                RD_HOLD: begin
                    request_rd_en_i = (row_cycle >= HOLD_CYCLES);
                end
                RD_RANDOM: begin
                    take_bits(1, bit_val);
                    request_rd_en_i = bit_val[0];
                end
                default: begin
                    request_rd_en_i = 1'b1;
                end
            endcase
        end
    endtask

    // ----------------------------
    // Cycle step
    // ----------------------------
    // Outputs are read and inputs driven 1 ns after the edge
    task automatic tick();
        @(posedge ap_clk);
        #1;
        cycle_cnt++;
        row_cycle++;
        if (cycle_cnt > timeout_limit) begin
            report_error("timeout, the run exceeded its cycle limit");
        end
        if (cu_bundles_i.u_props.fail_count != 0) begin
            report_error("a bound assertion on the DUT failed");
        end
        if (!started) begin
            check_value("done_o before first kernel", done_o, 0);
            check_value("request_o.valid before first kernel", request_o.valid, 0);
        end
        sample_request();
        descriptor_i.valid = 1'b0;
        drive_response();
        drive_read_enable();
    endtask

    // ----------------------------
    // Kernel table
    // ----------------------------
    // Expected is the sum of (word index + base/4 + 7) over every word
    task automatic load_table();
        int unsigned words;
        table_rows[0] = '{32'h0000_1000, 8'd8,  RD_ALWAYS, 40'd33488};
        table_rows[1] = '{32'h0000_4000, 8'd12, RD_HOLD,   40'd198072};
        table_rows[2] = '{32'h0002_0000, 8'd0,  RD_ALWAYS, 40'd0};
        table_rows[3] = '{32'h0001_0000, 8'd16, RD_RANDOM, 40'd1051040};
        table_rows[4] = '{32'h8000_0000, 8'd5,  RD_RANDOM, 40'd10737418570};
        words = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            words = words + table_rows[r].count;
        end
        timeout_limit = words * `CU_NUM_BUNDLES * 20 + 200;
    endtask

    task automatic run_row(input kernel_row_t row);
        cur = row;
        for (int i = 0; i < MAX_WORDS; i++) begin
            seen[i] = 1'b0;
        end
        req_seen      = 0;
        row_cycle     = 0;
        kernel_active = 1'b1;
        started       = 1'b1;
        descriptor_i.valid                = 1'b1;
        descriptor_i.payload.base_address = row.base;
        descriptor_i.payload.count        = row.count;
        drive_read_enable();
        tick();
        check_value("done_o after descriptor", done_o, 0);
        while (done_o !== 1'b1) begin
            tick();
        end
        kernel_active = 1'b0;
        check_value("result_o", result_o, row.expected);
        check_value("requests per kernel", req_seen, `CU_NUM_BUNDLES * row.count);
        check_value("responses pending at done", pending.size(), 0);
        // Quiet port after completion
        repeat (3) tick();
    endtask

    initial begin
        areset_cu_bundles = 1'b1;
        descriptor_i      = '0;
        response_i        = '0;
        request_rd_en_i   = 1'b0;
        lfsr_state        = 32'h0ab28c74;
        cycle_cnt         = 0;
        row_cycle         = 0;
        req_seen          = 0;
        kernel_active     = 1'b0;
        started           = 1'b0;
        cur               = '0;
        load_table();
        repeat (3) tick();
        areset_cu_bundles = 1'b0;
        // Idle after reset with nothing moving
        repeat (5) tick();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(table_rows[r]);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

/* verification/cu_bundles_props.sv */
/*
 * Concurrent properties on the compute unit top level
 * Memory port timing, grant exclusivity, completion ordering
 */

`timescale 1ns/10ps
`include "cu_bundles_defs.svh"

module cu_bundles_props (
    input logic                       ap_clk,
    input logic                       areset_cu_bundles,
    input logic                       descriptor_valid_i,
    input logic                       request_rd_en_i,
    input logic                       request_valid_i,
    input logic                       response_valid_i,
    input logic [`CU_NUM_BUNDLES-1:0] grant_i,
    input logic                       done_i
);

    // Requests sent on the memory port and not answered yet
    logic [7:0] outstanding;

    // Failed assertions so far
    int unsigned fail_count = 0;

    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 8'(request_valid_i) - 8'(response_valid_i);
        end
    end

    // ----------------------------
    // Properties
    // ----------------------------
    // Valid follows a cycle with read enable high
    a_valid_after_rd_en: assert property (
        @(posedge ap_clk) disable iff (areset_cu_bundles)
        request_valid_i |-> $past(request_rd_en_i)
    ) else begin
        $error("request valid without read enable in the previous cycle");
        fail_count++;
    end

    a_single_grant: assert property (
        @(posedge ap_clk) disable iff (areset_cu_bundles)
        $onehot0(grant_i)
    ) else begin
        $error("more than one bundle granted in a cycle");
        fail_count++;
    end

    // All answers back before completion
    a_done_no_pending: assert property (
        @(posedge ap_clk) disable iff (areset_cu_bundles)
        $rose(done_i) |-> (outstanding == '0)
    ) else begin
        $error("done rose with memory requests still outstanding");
        fail_count++;
    end

    a_done_cleared_by_start: assert property (
        @(posedge ap_clk) disable iff (areset_cu_bundles)
        descriptor_valid_i |=> !done_i
    ) else begin
        $error("done high right after a descriptor strobe");
        fail_count++;
    end

endmodule

bind cu_bundles cu_bundles_props u_props (
    .ap_clk             (ap_clk),
    .areset_cu_bundles  (areset_cu_bundles),
    .descriptor_valid_i (descriptor_i.valid),
    .request_rd_en_i    (request_rd_en_i),
    .request_valid_i    (request_o.valid),
    .response_valid_i   (response_i.valid),
    .grant_i            (bundle_grant),
    .done_i             (done_o)
);

/* design/cu_bundles.sv */
/*
 * Compute unit top level
 * Kernel control, response router, bundle engines and request arbiter
 */

`timescale 1ns/10ps
`include "cu_bundles_defs.svh"

module cu_bundles (
    input  logic                              ap_clk,
    input  logic                              areset_cu_bundles,
    input  cu_kernel_pkg::kernel_descriptor_t descriptor_i,
    input  cu_mem_pkg::mem_packet_t           response_i,
    input  logic                              request_rd_en_i,
    output cu_mem_pkg::mem_packet_t           request_o,
    output logic                              done_o,
    output logic [`CU_SUM_W-1:0]              result_o
);

    // ----------------------------
    // Internal wires
    // ----------------------------
    cu_kernel_pkg::kernel_descriptor_t bundle_descriptor;
    cu_mem_pkg::mem_packet_t           bundle_response [`CU_NUM_BUNDLES];
    cu_mem_pkg::mem_packet_t           bundle_request  [`CU_NUM_BUNDLES];
    logic [`CU_NUM_BUNDLES-1:0]        bundle_grant;
    logic [`CU_NUM_BUNDLES-1:0]        bundle_done;
    logic [`CU_SUM_W-1:0]              bundle_sum      [`CU_NUM_BUNDLES];
    logic                              fifo_empty;

    // Descriptor broadcast and completion
    cu_kernel_control u_control (
        .ap_clk              (ap_clk),
        .areset_cu_bundles   (areset_cu_bundles),
        .descriptor_i        (descriptor_i),
        .bundle_done_i       (bundle_done),
        .bundle_sum_i        (bundle_sum),
        .fifo_empty_i        (fifo_empty),
        .bundle_descriptor_o (bundle_descriptor),
        .done_o              (done_o),
        .result_o            (result_o)
    );

    // Memory responses back to their bundle
    cu_response_router #(.NUM_RESPONDERS(`CU_NUM_BUNDLES)) u_router (
        .ap_clk            (ap_clk),
        .areset_cu_bundles (areset_cu_bundles),
        .response_i        (response_i),
        .bundle_response_o (bundle_response)
    );

    // ----------------------------
    // Bundle engines
    // ----------------------------
    for (genvar j = 0; j < `CU_NUM_BUNDLES; j++) begin : g_bundle
        cu_bundle_engine #(.BUNDLE_ID(j)) u_engine (
            .ap_clk            (ap_clk),
            .areset_cu_bundles (areset_cu_bundles),
            .descriptor_i      (bundle_descriptor),
            .response_i        (bundle_response[j]),
            .grant_i           (bundle_grant[j]),
            .request_o         (bundle_request[j]),
            .done_o            (bundle_done[j]),
            .sum_o             (bundle_sum[j])
        );
    end

    // Bundle requests merged onto the memory port
    cu_request_arbiter #(.NUM_REQUESTORS(`CU_NUM_BUNDLES)) u_arbiter (
        .ap_clk            (ap_clk),
        .areset_cu_bundles (areset_cu_bundles),
        .request_i         (bundle_request),
        .grant_o           (bundle_grant),
        .rd_en_i           (request_rd_en_i),
        .request_o         (request_o),
        .fifo_empty_o      (fifo_empty)
    );

endmodule

/* design/cu_request_arbiter.sv */
/*
 * Request arbiter
 * Round-robin N-to-1 grant into a request FIFO, registered memory output
 */

`timescale 1ns/10ps
`include "cu_bundles_defs.svh"

module cu_request_arbiter #(
    parameter int NUM_REQUESTORS = `CU_NUM_BUNDLES
) (
    input  logic                      ap_clk,
    input  logic                      areset_cu_bundles,
    input  cu_mem_pkg::mem_packet_t   request_i [NUM_REQUESTORS],
    output logic [NUM_REQUESTORS-1:0] grant_o,
    input  logic                      rd_en_i,
    output cu_mem_pkg::mem_packet_t   request_o,
    output logic                      fifo_empty_o
);

    localparam int PTR_W  = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;
    localparam int ADDR_W = $clog2(`CU_REQ_FIFO_DEPTH);
    localparam int CNT_W  = ADDR_W + 1;

    logic [PTR_W-1:0]       rr_ptr;
    logic [PTR_W-1:0]       grant_idx;
    logic                   can_push;
    logic                   push;
    logic                   pop;
    logic [ADDR_W-1:0]      wr_ptr;
    logic [ADDR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]       fill;
    cu_mem_pkg::mem_payload_t fifo_mem [`CU_REQ_FIFO_DEPTH];

    // ----------------------------
    // Round-robin select
    // ----------------------------
    // Headroom above threshold absorbs nothing, one push per cycle
    assign can_push = (fill < CNT_W'(`CU_REQ_FIFO_THRESH));

    always_comb begin
        int unsigned idx;
        logic        found;
        grant_o   = '0;
        grant_idx = rr_ptr;
        found     = 1'b0;
        // Scan starting at the pointer
        for (int k = 0; k < NUM_REQUESTORS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_REQUESTORS;
            if (!found && can_push && request_i[idx].valid) begin
                grant_o[idx] = 1'b1;
                grant_idx    = PTR_W'(idx);
                found        = 1'b1;
            end
        end
    end

    assign push = |grant_o;

    // Winner gets lowest priority next time
    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            rr_ptr <= '0;
        end else if (push) begin
            if (int'(grant_idx) == NUM_REQUESTORS - 1) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= grant_idx + 1'b1;
            end
        end
    end

    // ----------------------------
    // Request FIFO
    // ----------------------------
    assign pop          = rd_en_i && (fill != '0);
    assign fifo_empty_o = (fill == '0);

    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the level
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Storage, written in the grant cycle
    always_ff @(posedge ap_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= request_i[grant_idx].payload;
        end
    end

    // ----------------------------
    // Memory port
    // ----------------------------
    // Head shows up one cycle after the pop
    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            request_o.valid <= 1'b0;
        end else begin
            request_o.valid <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_o.payload <= fifo_mem[rd_ptr];
    end

endmodule

/* design/cu_bundle_engine.sv */
/*
 * Bundle engine
 * Issues read requests over its word slice and accumulates the responses
 */

`timescale 1ns/10ps
`include "cu_bundles_defs.svh"

module cu_bundle_engine #(
    parameter int BUNDLE_ID = 0
) (
    input  logic                              ap_clk,
    input  logic                              areset_cu_bundles,
    input  cu_kernel_pkg::kernel_descriptor_t descriptor_i,
    input  cu_mem_pkg::mem_packet_t           response_i,
    input  logic                              grant_i,
    output cu_mem_pkg::mem_packet_t           request_o,
    output logic                              done_o,
    output logic [`CU_SUM_W-1:0]              sum_o
);

    logic                  busy;
    logic                  req_valid;
    logic [`CU_ADDR_W-1:0] req_addr;
    logic [`CU_CNT_W-1:0]  count_r;
    logic [`CU_CNT_W-1:0]  grant_cnt;
    logic [`CU_CNT_W-1:0]  rsp_cnt;
    logic [`CU_ADDR_W-1:0] slice_offset;
    logic                  rsp_hit;

    // Start of this bundle's slice, relative to base
    assign slice_offset = `CU_ADDR_W'(BUNDLE_ID)
                        * `CU_ADDR_W'(descriptor_i.payload.count)
                        * `CU_ADDR_W'(`CU_WORD_BYTES);

    // Only read responses carry data to add
    assign rsp_hit = response_i.valid
                  && (response_i.payload.meta.cmd == cu_mem_pkg::CMD_READ_RSP);

    // ----------------------------
    // Request sequencer
    // ----------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            req_valid <= 1'b0;
            grant_cnt <= '0;
        end else if (descriptor_i.valid) begin
            // Empty slice issues nothing
            req_valid <= (descriptor_i.payload.count != '0);
            grant_cnt <= '0;
        end else if (grant_i && req_valid) begin
            grant_cnt <= grant_cnt + 1'b1;
            // Last word just granted
            if (grant_cnt + 1'b1 == count_r) begin
                req_valid <= 1'b0;
            end
        end
    end

    // Address and count are payload, reloaded per kernel
    always_ff @(posedge ap_clk) begin
        if (descriptor_i.valid) begin
            req_addr <= descriptor_i.payload.base_address + slice_offset;
            count_r  <= descriptor_i.payload.count;
        end else if (grant_i && req_valid) begin
            req_addr <= req_addr + `CU_ADDR_W'(`CU_WORD_BYTES);
        end
    end

    // Pending request, tagged with our ID
    assign request_o.valid                = req_valid;
    assign request_o.payload.meta.cmd     = cu_mem_pkg::CMD_READ_REQ;
    assign request_o.payload.meta.id      = `CU_BUNDLE_ID_W'(BUNDLE_ID);
    assign request_o.payload.word.address = req_addr;

    // ----------------------------
    // Response accumulator
    // ----------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            busy    <= 1'b0;
            done_o  <= 1'b0;
            rsp_cnt <= '0;
            sum_o   <= '0;
        end else if (descriptor_i.valid) begin
            busy    <= 1'b1;
            done_o  <= 1'b0;
            rsp_cnt <= '0;
            sum_o   <= '0;
        end else begin
            if (rsp_hit) begin
                rsp_cnt <= rsp_cnt + 1'b1;
                sum_o   <= sum_o + `CU_SUM_W'(response_i.payload.word.data);
            end
            // All responses back, level holds until next kernel
            if (busy && (rsp_cnt == count_r)) begin
                busy   <= 1'b0;
                done_o <= 1'b1;
            end
        end
    end

endmodule

/* design/cu_response_router.sv */
/*
 * Response router
 * Registers each memory response and steers it to one bundle by ID
 */

`timescale 1ns/10ps
`include "cu_bundles_defs.svh"

module cu_response_router #(
    parameter int NUM_RESPONDERS = `CU_NUM_BUNDLES
) (
    input  logic                    ap_clk,
    input  logic                    areset_cu_bundles,
    input  cu_mem_pkg::mem_packet_t response_i,
    output cu_mem_pkg::mem_packet_t bundle_response_o [NUM_RESPONDERS]
);

    cu_mem_pkg::mem_packet_t rsp_reg;

    // ----------------------------
    // Input register
    // ----------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            rsp_reg.valid <= 1'b0;
        end else begin
            rsp_reg.valid <= response_i.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        rsp_reg.payload <= response_i.payload;
    end

    // ----------------------------
    // ID decode
    // ----------------------------
    // Payload fans out to all lanes, valid only on the matching one
    for (genvar i = 0; i < NUM_RESPONDERS; i++) begin : g_lane
        assign bundle_response_o[i].valid =
            rsp_reg.valid && (rsp_reg.payload.meta.id == `CU_BUNDLE_ID_W'(i));
        assign bundle_response_o[i].payload = rsp_reg.payload;
    end

endmodule

/* design/cu_kernel_control.sv */
/*
 * Kernel control
 * Two-stage descriptor register with broadcast, done aggregation, result sum
 */

`timescale 1ns/10ps
`include "cu_bundles_defs.svh"

module cu_kernel_control (
    input  logic                              ap_clk,
    input  logic                              areset_cu_bundles,
    input  cu_kernel_pkg::kernel_descriptor_t descriptor_i,
    input  logic [`CU_NUM_BUNDLES-1:0]        bundle_done_i,
    input  logic [`CU_SUM_W-1:0]              bundle_sum_i [`CU_NUM_BUNDLES],
    input  logic                              fifo_empty_i,
    output cu_kernel_pkg::kernel_descriptor_t bundle_descriptor_o,
    output logic                              done_o,
    output logic [`CU_SUM_W-1:0]              result_o
);

    cu_kernel_pkg::kernel_descriptor_t desc_stage;
    logic                              kick;
    logic [`CU_SUM_W-1:0]              sum_total;

    // ----------------------------
    // Descriptor pipeline
    // ----------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            desc_stage.valid          <= 1'b0;
            bundle_descriptor_o.valid <= 1'b0;
        end else begin
            desc_stage.valid          <= descriptor_i.valid;
            bundle_descriptor_o.valid <= desc_stage.valid;
        end
    end

    // Payload follows its valid
    always_ff @(posedge ap_clk) begin
        desc_stage.payload          <= descriptor_i.payload;
        bundle_descriptor_o.payload <= desc_stage.payload;
    end

    // ----------------------------
    // Completion
    // ----------------------------
    // Old bundle done levels linger until the broadcast lands
    assign kick = descriptor_i.valid | desc_stage.valid | bundle_descriptor_o.valid;

    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            done_o <= 1'b0;
        end else if (kick) begin
            done_o <= 1'b0;
        end else begin
            done_o <= (&bundle_done_i) & fifo_empty_i;
        end
    end

    // Bundle sums are stable once each bundle is done
    always_comb begin
        sum_total = '0;
        for (int i = 0; i < `CU_NUM_BUNDLES; i++) begin
            sum_total = sum_total + bundle_sum_i[i];
        end
    end

    always_ff @(posedge ap_clk) begin
        result_o <= sum_total;
    end

endmodule

/* design/cu_kernel_pkg.sv */
/*
 * Kernel descriptor types
 * Base address and per-bundle word count
 */

`include "cu_bundles_defs.svh"

package cu_kernel_pkg;

    // Same count for every bundle, slices are contiguous
    typedef struct packed {
        logic [`CU_ADDR_W-1:0] base_address;
        logic [`CU_CNT_W-1:0]  count;
    } kernel_payload_t;

    // Valid is a one-cycle start strobe
    typedef struct packed {
        logic            valid;
        kernel_payload_t payload;
    } kernel_descriptor_t;

endpackage

/* design/cu_mem_pkg.sv */
/*
 * Memory packet types
 * Command, metadata, address/data word union and the packet itself
 */

`include "cu_bundles_defs.svh"

package cu_mem_pkg;

    // ----------------------------
    // Packet header
    // ----------------------------
    typedef enum logic [0:0] {
        CMD_READ_REQ = 1'b0,
        CMD_READ_RSP = 1'b1
    } mem_cmd_t;

    // Bundle ID routes the response back
    typedef struct packed {
        mem_cmd_t                    cmd;
        logic [`CU_BUNDLE_ID_W-1:0] id;
    } mem_meta_t;

    // ----------------------------
    // Packet body
    // ----------------------------
    // Address on the way out, data on the way back
    typedef union packed {
        logic [`CU_ADDR_W-1:0] address;
        logic [`CU_DATA_W-1:0] data;
    } mem_word_u;

    typedef struct packed {
        mem_meta_t meta;
        mem_word_u word;
    } mem_payload_t;

    typedef struct packed {
        logic         valid;
        mem_payload_t payload;
    } mem_packet_t;

endpackage

/* include/cu_bundles_defs.svh */
/*
 * Shared sizing macros for the compute unit
 * Bundle count, packet field widths, address step and request FIFO sizing
 */

`ifndef CU_BUNDLES_DEFS_SVH
`define CU_BUNDLES_DEFS_SVH

// Bundle engines behind one descriptor
`define CU_NUM_BUNDLES 4
`define CU_BUNDLE_ID_W 2

// Packet field widths, address and data share one word
`define CU_ADDR_W 32
`define CU_DATA_W 32
`define CU_CNT_W 8
`define CU_SUM_W 40

// Byte step between consecutive words
`define CU_WORD_BYTES 4

// Request FIFO depth and almost-full level
`define CU_REQ_FIFO_DEPTH 8
`define CU_REQ_FIFO_THRESH 6

`endif
